// ==== rtl/memCtrl_defines.svh ====
`ifndef MEM_CTRL_DEFINES_SVH
`define MEM_CTRL_DEFINES_SVH

// processor address space
`define MEM_ADDR_W 32

// instruction and data word
`define MEM_WORD_W 32

// ram data bus, one byte per access
`define MEM_BYTE_W 8

// bytes per instruction fetch
`define MEM_FETCH_LEN 4

`endif

// ==== rtl/memCtrlPkg.sv ====
package memCtrlPkg;

    // who currently holds the ram
    typedef enum logic [1:0] {
        ownerIdle  = 2'b00,
        ownerData  = 2'b01,
        ownerFetch = 2'b10
    } ownerT;

    // byte count of one access, legal values 1, 2 and 4
    typedef logic [2:0] accessLenT;

    // what an accepted request does
    typedef enum logic [1:0] {
        kindFetch,
        kindLoad,
        kindStore
    } accessKindT;

endpackage

// ==== rtl/memReqIf.sv ====
`include "memCtrl_defines.svh"

interface memReqIf;
    logic                     start;
    memCtrlPkg::accessKindT   kind;
    logic [`MEM_ADDR_W-1:0]   addr;
    memCtrlPkg::accessLenT    len;
    logic [`MEM_WORD_W-1:0]   wdata;
    // last byte of the access is on the ram bus
    logic                     finish;

    modport arbiter (
        output start, kind, addr, len, wdata,
        input  finish
    );

    modport sequencer (
        input  start, kind, addr, len, wdata,
        output finish
    );
endinterface

// ==== rtl/byteStreamIf.sv ====
`include "memCtrl_defines.svh"

interface byteStreamIf;
    logic                               byteValid;
    logic [$clog2(`MEM_FETCH_LEN)-1:0]  byteIdx;
    // also set for a store, with byteValid low
    logic                               last;
    memCtrlPkg::accessKindT             kind;
    logic [`MEM_BYTE_W-1:0]             rbyte;

    modport sequencer (
        output byteValid, byteIdx, last, kind, rbyte
    );

    modport assembler (
        input byteValid, byteIdx, last, kind, rbyte
    );
endinterface

// ==== rtl/memRequestArbiter.sv ====
`include "memCtrl_defines.svh"

module memRequestArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hold,
    input  logic                   dcEn,
    input  logic                   dcStore,
    input  memCtrlPkg::accessLenT  dcLen,
    input  logic [`MEM_WORD_W-1:0] dcWdata,
    input  logic [`MEM_ADDR_W-1:0] dcAddr,
    input  logic                   infEn,
    input  logic [`MEM_ADDR_W-1:0] infAddr,
    output memCtrlPkg::ownerT      owner,
    memReqIf.arbiter               req
);
    logic idle;

    assign idle = (owner == memCtrlPkg::ownerIdle);

    // owner and start pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            owner     <= memCtrlPkg::ownerIdle;
            req.start <= 1'b0;
        end else if (!hold) begin
            req.start <= 1'b0;
            if (idle) begin
                // data port wins a tie
                if (dcEn) begin
                    owner     <= memCtrlPkg::ownerData;
                    req.start <= 1'b1;
                end else if (infEn) begin
                    owner     <= memCtrlPkg::ownerFetch;
                    req.start <= 1'b1;
                end
            end else if (req.finish) begin
                owner <= memCtrlPkg::ownerIdle;
            end
        end
    end

    // latched request
    always_ff @(posedge clk) begin
        if (!hold && idle) begin
            if (dcEn) begin
                req.kind  <= dcStore ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad;
                req.addr  <= dcAddr;
                req.len   <= dcLen;
                req.wdata <= dcWdata;
            end else if (infEn) begin
                req.kind  <= memCtrlPkg::kindFetch;
                req.addr  <= infAddr;
                req.len   <= memCtrlPkg::accessLenT'(`MEM_FETCH_LEN);
                req.wdata <= '0;
            end
        end
    end

endmodule

// ==== rtl/memByteSequencer.sv ====
`include "memCtrl_defines.svh"

module memByteSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hold,
    input  logic [`MEM_BYTE_W-1:0] memDin,
    output logic                   memWe,
    output logic [`MEM_ADDR_W-1:0] memAddr,
    output logic [`MEM_BYTE_W-1:0] memDout,
    memReqIf.sequencer             req,
    byteStreamIf.sequencer         bytes
);
    localparam int idxW = $clog2(`MEM_FETCH_LEN);

    logic                   busy;
    logic                   active;
    logic                   isStore;
    memCtrlPkg::accessLenT  cnt;
    memCtrlPkg::accessLenT  nextCnt;
    logic                   tagValid;
    logic                   tagLast;
    logic [idxW-1:0]        tagIdx;
    memCtrlPkg::accessKindT tagKind;
    logic                   holdPrev;
    logic [`MEM_BYTE_W-1:0] capByte;

    // first byte goes out in the start cycle
    assign active     = req.start | busy;
    assign isStore    = (req.kind == memCtrlPkg::kindStore);
    assign nextCnt    = cnt + 3'd1;
    assign req.finish = active && (nextCnt == req.len);

    assign memAddr = active ? req.addr + `MEM_ADDR_W'(cnt) : '0;
    assign memWe   = active && isStore && !hold;
    assign memDout = (active && isStore) ?
                     req.wdata[cnt[idxW-1:0]*`MEM_BYTE_W +: `MEM_BYTE_W] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            tagValid <= 1'b0;
            tagLast  <= 1'b0;
        end else if (!hold) begin
            tagValid <= active && !isStore;
            tagLast  <= req.finish;
            if (active) begin
                busy <= !req.finish;
                cnt  <= req.finish ? '0 : nextCnt;
            end
        end
    end

    // tag for the byte the ram returns next cycle
    always_ff @(posedge clk) begin
        if (!hold) begin
            tagIdx  <= cnt[idxW-1:0];
            tagKind <= req.kind;
        end
    end

    // the first held cycle still carries the byte addressed just before the stall,
    // later held cycles already show the next address
    always_ff @(posedge clk) begin
        if (rst) begin
            holdPrev <= 1'b0;
        end else begin
            holdPrev <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (hold && !holdPrev) begin
            capByte <= memDin;
        end
    end

    assign bytes.byteValid = tagValid;
    assign bytes.byteIdx   = tagIdx;
    assign bytes.last      = tagLast;
    assign bytes.kind      = tagKind;
    assign bytes.rbyte     = holdPrev ? capByte : memDin;

endmodule

// ==== rtl/memResultAssembler.sv ====
`include "memCtrl_defines.svh"

module memResultAssembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hold,
    output logic                   infDone,
    output logic [`MEM_WORD_W-1:0] infInst,
    output logic                   bpEn,
    output logic [`MEM_WORD_W-1:0] bpInst,
    output logic                   dcDone,
    output logic [`MEM_WORD_W-1:0] dcRdata,
    byteStreamIf.assembler         bytes
);
    logic [`MEM_WORD_W-1:0] word;
    logic [`MEM_WORD_W-1:0] nextWord;

    // little-endian lanes, upper lanes stay zero for short loads
    always_comb begin
        nextWord = word;
        if (bytes.byteValid) begin
            if (bytes.byteIdx == '0) begin
                nextWord = '0;
            end
            nextWord[bytes.byteIdx*`MEM_BYTE_W +: `MEM_BYTE_W] = bytes.rbyte;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && bytes.byteValid) begin
            word <= nextWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            infDone <= 1'b0;
            infInst <= '0;
            bpEn    <= 1'b0;
            bpInst  <= '0;
            dcDone  <= 1'b0;
            dcRdata <= '0;
        end else if (!hold) begin
            infDone <= 1'b0;
            bpEn    <= 1'b0;
            dcDone  <= 1'b0;
            if (bytes.last) begin
                case (bytes.kind)
                    memCtrlPkg::kindFetch: begin
                        infDone <= 1'b1;
                        infInst <= nextWord;
                        // predictor sees every fetched instruction
                        bpEn    <= 1'b1;
                        bpInst  <= nextWord;
                    end
                    memCtrlPkg::kindLoad: begin
                        dcDone  <= 1'b1;
                        dcRdata <= nextWord;
                    end
                    memCtrlPkg::kindStore: begin
                        dcDone <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/memCtrl.sv ====
`include "memCtrl_defines.svh"

module memCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,

    // ram
    input  logic [`MEM_BYTE_W-1:0] memDin,
    output logic                   memWe,
    output logic [`MEM_ADDR_W-1:0] memAddr,
    output logic [`MEM_BYTE_W-1:0] memDout,

    output memCtrlPkg::ownerT      owner,

    // instruction fetch
    input  logic                   infEn,
    input  logic [`MEM_ADDR_W-1:0] infAddr,
    output logic                   infDone,
    output logic [`MEM_WORD_W-1:0] infInst,
    output logic                   bpEn,
    output logic [`MEM_WORD_W-1:0] bpInst,

    // load/store
    input  logic                   dcEn,
    input  logic                   dcStore,
    input  memCtrlPkg::accessLenT  dcLen,
    input  logic [`MEM_WORD_W-1:0] dcWdata,
    input  logic [`MEM_ADDR_W-1:0] dcAddr,
    output logic                   dcDone,
    output logic [`MEM_WORD_W-1:0] dcRdata
);
    logic hold;

    memReqIf     reqBus ();
    byteStreamIf byteBus ();

    // global stall freezes every block
    assign hold = !rdy || ioBufferFull;

    memRequestArbiter arbiter (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .dcEn    (dcEn),
        .dcStore (dcStore),
        .dcLen   (dcLen),
        .dcWdata (dcWdata),
        .dcAddr  (dcAddr),
        .infEn   (infEn),
        .infAddr (infAddr),
        .owner   (owner),
        .req     (reqBus)
    );

    memByteSequencer sequencer (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .memDin  (memDin),
        .memWe   (memWe),
        .memAddr (memAddr),
        .memDout (memDout),
        .req     (reqBus),
        .bytes   (byteBus)
    );

    memResultAssembler assembler (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .infDone (infDone),
        .infInst (infInst),
        .bpEn    (bpEn),
        .bpInst  (bpInst),
        .dcDone  (dcDone),
        .dcRdata (dcRdata),
        .bytes   (byteBus)
    );

endmodule

// ==== verification/memCtrlTb.sv ====
`include "memCtrl_defines.svh"

module memCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst, rdy, ioBufferFull, memWe, infEn, infDone, bpEn;
    logic dcEn, dcStore, dcDone, tbHold, stallOn, seenEnable, expLoad;
    logic [`MEM_BYTE_W-1:0] memDin = '0;
    logic [`MEM_BYTE_W-1:0] memDout;
    logic [`MEM_ADDR_W-1:0] memAddr, infAddr, dcAddr;
    logic [`MEM_WORD_W-1:0] infInst, bpInst, dcWdata, dcRdata, expInst, expRdata;
    memCtrlPkg::ownerT      owner;
    memCtrlPkg::accessLenT  dcLen;
    memCtrlPkg::accessLenT  lens [3] = '{3'd1, 3'd2, 3'd4};
    logic [7:0]             ram [256];
    logic [7:0]             refMem [256];

    memCtrl dut (.*);

    assign tbHold = !rdy || ioBufferFull;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous ram, read data one cycle after the address
    always @(posedge clk) begin
        if (memWe) ram[memAddr[7:0]] <= memDout;
        memDin <= ram[memAddr[7:0]];
    end

    // random back-pressure while stallOn is set
    initial begin
        logic stallNow;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            @(posedge clk);
            stallNow = stallOn;
            #1;
            rdy = stallNow ? ($urandom % 4 != 0) : 1'b1;
            ioBufferFull = stallNow ? ($urandom % 6 == 0) : 1'b0;
        end
    end

    task automatic reportFailure(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportTimeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    assert property (@(posedge clk) disable iff (rst) !seenEnable |-> owner ==
        memCtrlPkg::ownerIdle && !memWe && !infDone && !bpEn && !dcDone)
        else reportFailure("controller not quiet before the first enable");
    assert property (@(posedge clk) disable iff (rst) infDone |-> infInst == expInst)
        else reportFailure($sformatf("infInst %h, expected %h", infInst, expInst));
    assert property (@(posedge clk) disable iff (rst) dcDone && expLoad |-> dcRdata == expRdata)
        else reportFailure($sformatf("dcRdata %h, expected %h", dcRdata, expRdata));
    assert property (@(posedge clk) disable iff (rst) bpEn == infDone && bpInst == infInst)
        else reportFailure("branch predictor tap differs from fetch output");
    assert property (@(posedge clk) disable iff (rst) !(tbHold && memWe))
        else reportFailure("memWe high in a held cycle");
    assert property (@(posedge clk) disable iff (rst) infDone && !tbHold |=> !infDone)
        else reportFailure("infDone longer than one unheld cycle");
    assert property (@(posedge clk) disable iff (rst) dcDone && !tbHold |=> !dcDone)
        else reportFailure("dcDone longer than one unheld cycle");

    // acceptance is the edge that finds the owner idle and no stall
    task automatic waitAccept(input memCtrlPkg::ownerT expOwner);
        int n = 0;
        logic accepted;
        accepted = 1'b0;
        while (!accepted && n < 50) begin
            @(negedge clk);
            accepted = (owner == memCtrlPkg::ownerIdle) && !tbHold;
            @(posedge clk);
            n++;
        end
        if (!accepted)
            reportTimeout("request was never accepted");
        #1;
        assert (owner == expOwner) else reportFailure($sformatf("owner %s", owner.name()));
    endtask

    task automatic waitDone(input logic fetch, output int lat);
        int n = 0;
        logic seen;
        lat = 0;
        seen = 1'b0;
        while (!seen && lat < 50) begin
            @(negedge clk);
            lat++;
            seen = fetch ? infDone : dcDone;
        end
        if (!seen)
            reportTimeout(fetch ? "infDone never came" : "dcDone never came");
        // a held pulse must be over before new expectations are set
        while (seen && n < 50) begin
            @(negedge clk);
            n++;
            seen = fetch ? infDone : dcDone;
        end
        if (seen) reportTimeout("done pulse never ended");
        @(posedge clk);
        #1;
    endtask

    task automatic runFetch(input logic [31:0] addr, input logic checkLat);
        int k, lat;
        for (k = 0; k < 4; k++) expInst[8*k +: 8] = refMem[8'(addr + k)];
        infAddr = addr;
        infEn = 1'b1;
        seenEnable = 1'b1;
        waitAccept(memCtrlPkg::ownerFetch);
        infEn = 1'b0;
        waitDone(1'b1, lat);
        if (checkLat) assert (lat == 6) else reportFailure($sformatf("fetch took %0d", lat));
    endtask

    task automatic runData(input logic store, input memCtrlPkg::accessLenT len,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic checkLat);
        int k, lat;
        expLoad = !store;
        expRdata = '0;
        for (k = 0; k < int'(len); k++) begin
            if (store) refMem[8'(addr + k)] = wdata[8*k +: 8];
            else expRdata[8*k +: 8] = refMem[8'(addr + k)];
        end
        {dcStore, dcLen, dcAddr, dcWdata, dcEn, seenEnable} = {store, len, addr, wdata, 2'b11};
        waitAccept(memCtrlPkg::ownerData);
        dcEn = 1'b0;
        waitDone(1'b0, lat);
        if (checkLat)
            assert (lat == int'(len) + 2)
            else reportFailure($sformatf("data took %0d", lat));
        for (k = 0; k < 256; k++)
            assert (ram[k] === refMem[k]) else reportFailure($sformatf("ram byte %0d wrong", k));
    endtask

    initial begin
        int i, k, lat;
        void'($urandom(32'h7463ffde));
        {rst, dcEn, dcStore, infEn, stallOn, seenEnable, expLoad} = 7'b1000000;
        {dcLen, dcWdata, dcAddr, infAddr, expInst, expRdata} = '0;
        for (i = 0; i < 256; i++) begin
            ram[i] = 8'(i * 29 + 60);
            refMem[i] = ram[i];
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        for (i = 0; i < 4; i++) runFetch($urandom % 256, 1'b1);
        for (i = 0; i < 3; i++) begin
            k = $urandom % 256;
            runData(1'b0, lens[i], k, '0, 1'b1);
            runData(1'b1, lens[i], k, $urandom, 1'b1);
            runData(1'b0, lens[i], k, '0, 1'b1);
        end
        // data and fetch in the same cycle
        expLoad = 1'b1;
        {dcStore, dcLen, dcAddr, infAddr} = {1'b0, 3'd4, 32'd16, 32'd200};
        for (k = 0; k < 4; k++) begin
            expRdata[8*k +: 8] = refMem[8'(16 + k)];
            expInst[8*k +: 8] = refMem[8'(200 + k)];
        end
        {dcEn, infEn, seenEnable} = 3'b111;
        waitAccept(memCtrlPkg::ownerData);
        dcEn = 1'b0;
        waitAccept(memCtrlPkg::ownerFetch);
        infEn = 1'b0;
        waitDone(1'b0, lat);
        assert (owner == memCtrlPkg::ownerFetch) else reportFailure("fetch not owner after data");
        waitDone(1'b1, lat);
        assert (owner == memCtrlPkg::ownerIdle) else reportFailure("owner not idle at the end");
        stallOn = 1'b1;
        for (i = 0; i < 12; i++) begin
            k = $urandom % 3;
            if (k == 0) runFetch($urandom % 256, 1'b0);
            else runData(k == 2, lens[$urandom % 3], $urandom % 256, $urandom, 1'b0);
        end
        stallOn = 1'b0;
        repeat (4) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// ==== memCtrl.f ====
+incdir+rtl
rtl/memCtrlPkg.sv
rtl/memReqIf.sv
rtl/byteStreamIf.sv
rtl/memRequestArbiter.sv
rtl/memByteSequencer.sv
rtl/memResultAssembler.sv
rtl/memCtrl.sv
verification/memCtrlTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := memCtrlTb
RTL_TOP    := memCtrl
FILELIST   := memCtrl.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
